//--- rtl/irq_pkg.sv
package irq_pkg;

	// Interrupt sources, one per IF/IE bit
	localparam int NUM_IRQ = 8;

	// CPU bus widths
	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	// IE lives at the very top of the address space
	localparam logic [ADDR_W-1:0] IE_ADDR = 16'hFFFF;

	// Binary index of one source
	localparam int IDX_W = 3;

	// Dispatch vector field, address bits 7..3
	localparam int VEC_W = 5;

endpackage

//--- rtl/irq_enable_reg.sv
`timescale 1ns/1ps

module irq_enable_reg ( clk, reset, addr, wdata, wr, rd, ie, ie_hit, rdata );

	input clk;
	input reset;
	input [irq_pkg::ADDR_W-1:0] addr;		// CPU address bus
	input [irq_pkg::DATA_W-1:0] wdata;		// CPU write data
	input wr;					// Write strobe
	input rd;					// Read strobe
	output logic [irq_pkg::NUM_IRQ-1:0] ie;	// Interrupt enable mask
	output logic ie_hit;				// Address is IE
	output logic [irq_pkg::DATA_W-1:0] rdata;	// Zero when not selected

	logic ie_wr;			// Write hitting IE this cycle
	logic ie_rd;			// Read hitting IE this cycle

	// Full 16-bit compare
	always_comb begin
		ie_hit = (addr == irq_pkg::IE_ADDR);
	end

	always_comb begin
		ie_wr = wr & ie_hit;
		ie_rd = rd & ie_hit;
	end

	// New mask usable from the next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			ie <= '0;			// All sources masked
		end else if (ie_wr) begin
			ie <= wdata[irq_pkg::NUM_IRQ-1:0];
		end
	end

	// Read mux onto the data bus
	always_comb begin
		if (ie_rd) begin
			rdata = irq_pkg::DATA_W'(ie);
		end else begin
			rdata = '0;
		end
	end

	// The shared read bus relies on this staying quiet outside reads
	a_rdata_idle: assert property (
		@(posedge clk) !rd |-> (rdata == '0)
	) else $error("rdata driven while rd is low");

endmodule

//--- rtl/irq_request_stage.sv
`timescale 1ns/1ps

module irq_request_stage ( clk, reset, trig, ie, pending, wake );

	input clk;
	input reset;
	input [irq_pkg::NUM_IRQ-1:0] trig;		// IF flag levels from outside
	input [irq_pkg::NUM_IRQ-1:0] ie;		// Enable mask
	output logic [irq_pkg::NUM_IRQ-1:0] pending;	// Registered masked requests
	output logic wake;				// Leave HALT

	logic [irq_pkg::NUM_IRQ-1:0] masked;	// Requests passing IE
	logic any_masked;				// At least one request passes

	always_comb begin
		masked = trig & ie;
		any_masked = |masked;
	end

	// One register stage for both the set and its summary
	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
			wake <= 1'b0;
		end else begin
			pending <= masked;
			// Wake ignores dispatch gating so HALT can exit with IME off
			wake <= any_masked;
		end
	end

	// Wake and the pending set come from the same sample
	a_wake_matches: assert property (
		@(posedge clk) disable iff (reset)
		wake == (|pending)
	) else $error("wake out of step with pending");

endmodule

//--- rtl/irq_priority_stage.sv
`timescale 1ns/1ps

module irq_priority_stage ( clk, reset, pending, dispatch_en, seq_busy, ack );

	input clk;
	input reset;
	input [irq_pkg::NUM_IRQ-1:0] pending;	// Masked requests
	input dispatch_en;				// Decoder allows dispatch
	input seq_busy;				// Sequencer blocks dispatch
	output logic [irq_pkg::NUM_IRQ-1:0] ack;	// One-hot acknowledge

	logic [irq_pkg::NUM_IRQ-1:0] winner;	// Lowest set bit of pending
	logic [irq_pkg::NUM_IRQ-1:0] ack_next;	// Winner after gating
	logic allow;				// Dispatch permitted this cycle

	// Bit 0 has top priority
	always_comb begin
		logic found;
		found = 1'b0;
		winner = '0;
		for (int i = 0; i < irq_pkg::NUM_IRQ; i++) begin
			if (pending[i] && !found) begin
				winner[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	always_comb begin
		allow = dispatch_en & ~seq_busy;
		ack_next = allow ? winner : '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= '0;
		end else begin
			ack <= ack_next;		// Repeats while the flag is held
		end
	end

	// Only one source is serviced at a time
	a_ack_onehot: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(ack)
	) else $error("ack is not one-hot");

	// Never acknowledge something that was not pending
	a_ack_subset: assert property (
		@(posedge clk) disable iff (reset)
		##1 ((ack & ~$past(pending)) == '0)
	) else $error("ack outside previous pending set");

endmodule

//--- rtl/irq_vector_stage.sv
`timescale 1ns/1ps

module irq_vector_stage ( clk, reset, ack, dispatch_en, seq_busy, vector, taken );

	input clk;
	input reset;
	input [irq_pkg::NUM_IRQ-1:0] ack;		// One-hot acknowledge
	input dispatch_en;				// Decoder allows dispatch
	input seq_busy;				// Sequencer state bit
	output logic [irq_pkg::VEC_W-1:0] vector;	// Address bits 7..3
	output logic taken;				// Interrupt entered

	logic [irq_pkg::IDX_W-1:0] idx;		// Binary index of acknowledged source
	logic any_ack;				// Some source acknowledged
	logic vec_b3;					// Address bit 6
	logic vec_b4;					// Address bit 7

	// OR encoder, a zero ack gives index zero
	always_comb begin
		idx = '0;
		for (int i = 0; i < irq_pkg::NUM_IRQ; i++) begin
			if (ack[i]) begin
				idx = idx | irq_pkg::IDX_W'(i);
			end
		end
	end

	always_comb begin
		any_ack = |ack;
		vec_b3 = any_ack & dispatch_en;
		vec_b4 = seq_busy & dispatch_en;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vector <= '0;
			taken <= 1'b0;
		end else begin
			vector <= {vec_b4, vec_b3, idx};
			taken <= any_ack;
		end
	end

	// Taken implies bit 6 unless dispatch dropped during the ack cycle
	a_taken_vec: assert property (
		@(posedge clk) disable iff (reset)
		taken |-> (vector[3] || !$past(dispatch_en))
	) else $error("taken without vector bit 6");

	// An ack needs dispatch open one stage earlier
	a_taken_origin: assert property (
		@(posedge clk) disable iff (reset)
		taken |-> $past(dispatch_en, 2)
	) else $error("taken without dispatch enable upstream");

endmodule

//--- rtl/irq_top.sv
`timescale 1ns/1ps

module irq_top ( clk, reset, addr, wdata, wr, rd, trig, dispatch_en, seq_busy,
	rdata, ie_hit, wake, ack, vector, taken );

	input clk;
	input reset;
	input [irq_pkg::ADDR_W-1:0] addr;		// CPU address bus
	input [irq_pkg::DATA_W-1:0] wdata;		// CPU write data
	input wr;
	input rd;
	input [irq_pkg::NUM_IRQ-1:0] trig;		// IF flags
	input dispatch_en;				// Decoder enable
	input seq_busy;				// Sequencer blocks dispatch
	output [irq_pkg::DATA_W-1:0] rdata;		// IE read-back
	output ie_hit;				// Address is IE
	output wake;					// HALT exit
	output [irq_pkg::NUM_IRQ-1:0] ack;		// One-hot acknowledge
	output [irq_pkg::VEC_W-1:0] vector;		// Dispatch address bits 7..3
	output taken;				// Interrupt entered

	wire [irq_pkg::NUM_IRQ-1:0] ie;		// Enable mask
	wire [irq_pkg::NUM_IRQ-1:0] pending;	// Masked requests, stage 1

	irq_enable_reg u_ie (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.rd(rd),
		.ie(ie),
		.ie_hit(ie_hit),
		.rdata(rdata)
	);

	irq_request_stage u_req (
		.clk(clk),
		.reset(reset),
		.trig(trig),
		.ie(ie),
		.pending(pending),
		.wake(wake)
	);

	irq_priority_stage u_pri (
		.clk(clk),
		.reset(reset),
		.pending(pending),
		.dispatch_en(dispatch_en),
		.seq_busy(seq_busy),
		.ack(ack)
	);

	irq_vector_stage u_vec (
		.clk(clk),
		.reset(reset),
		.ack(ack),
		.dispatch_en(dispatch_en),
		.seq_busy(seq_busy),
		.vector(vector),
		.taken(taken)
	);

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen ( clk, reset );

	output logic clk;
	output logic reset;

	localparam int HALF_PERIOD = 4;		// 8 ns clock
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD) clk = ~clk;
		end
	end

	// Power-on reset, released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- test/tb_irq.sv
`timescale 1ns/1ps

module tb_irq;

	localparam int CYCLE_LIMIT = 600;	// About 100 directed, 300 random, plus margin
	localparam int RANDOM_CYCLES = 300;

	logic clk;
	logic por_reset;			// From the clock generator
	logic soft_reset;			// Mid-run reset
	logic reset;
	logic [irq_pkg::ADDR_W-1:0] addr;
	logic [irq_pkg::DATA_W-1:0] wdata;
	logic wr;
	logic rd;
	logic [irq_pkg::NUM_IRQ-1:0] trig;
	logic dispatch_en;
	logic seq_busy;
	logic [irq_pkg::DATA_W-1:0] rdata;
	logic ie_hit;
	logic wake;
	logic [irq_pkg::NUM_IRQ-1:0] ack;
	logic [irq_pkg::VEC_W-1:0] vector;
	logic taken;

	int seed = 49480;
	int err_count = 0;
	int timeout_count = 0;
	int cycle_count = 0;

	// Reference model state
	logic [irq_pkg::NUM_IRQ-1:0] m_ie;
	logic [irq_pkg::NUM_IRQ-1:0] d_trig [1:3];	// Index 1 is the most recent edge
	logic [irq_pkg::NUM_IRQ-1:0] d_ie [1:3];
	logic d_en [1:3];
	logic d_busy [1:3];
	logic d_rst [1:3] = '{1'b1, 1'b1, 1'b1};	// Masks history from before time zero
	logic chk_on = 1'b0;

	logic [irq_pkg::NUM_IRQ-1:0] exp_pend;
	logic [irq_pkg::NUM_IRQ-1:0] prev_pend;
	logic [irq_pkg::NUM_IRQ-1:0] old_pend;
	logic [irq_pkg::NUM_IRQ-1:0] exp_ack;
	logic [irq_pkg::NUM_IRQ-1:0] prev_ack;
	logic [irq_pkg::VEC_W-1:0] exp_vector;
	logic exp_wake;
	logic exp_taken;
	logic [irq_pkg::DATA_W-1:0] exp_rdata;

	assign reset = por_reset | soft_reset;

	tb_clock_gen u_clk (
		.clk(clk),
		.reset(por_reset)
	);

	irq_top dut0 (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.rd(rd),
		.trig(trig),
		.dispatch_en(dispatch_en),
		.seq_busy(seq_busy),
		.rdata(rdata),
		.ie_hit(ie_hit),
		.wake(wake),
		.ack(ack),
		.vector(vector),
		.taken(taken)
	);

	// Isolates the lowest set bit, bit 0 wins
	function automatic logic [irq_pkg::NUM_IRQ-1:0] lowest_one_hot(
		input logic [irq_pkg::NUM_IRQ-1:0] v);
		return v & (~v + 1'b1);
	endfunction

	function automatic logic [irq_pkg::IDX_W-1:0] one_hot_index(
		input logic [irq_pkg::NUM_IRQ-1:0] v);
		logic [irq_pkg::IDX_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < irq_pkg::NUM_IRQ; i++) begin
			if (v[i]) begin
				idx = irq_pkg::IDX_W'(i);
			end
		end
		return idx;
	endfunction

	function automatic logic [irq_pkg::NUM_IRQ-1:0] grant_of(
		input logic [irq_pkg::NUM_IRQ-1:0] pend, input logic en, input logic busy,
		input logic rst);
		if (rst || !en || busy) begin
			return '0;
		end
		return lowest_one_hot(pend);
	endfunction

	// Model IE and the input history, same edges as the DUT
	always @(posedge clk) begin
		if (reset) begin
			m_ie <= '0;
			chk_on <= 1'b1;
		end else if (wr && addr == irq_pkg::IE_ADDR) begin
			m_ie <= wdata;
		end
		d_trig[1] <= trig;
		d_ie[1] <= m_ie;			// Mask seen by the request stage
		d_en[1] <= dispatch_en;
		d_busy[1] <= seq_busy;
		d_rst[1] <= reset;
		for (int i = 3; i > 1; i--) begin
			d_trig[i] <= d_trig[i-1];
			d_ie[i] <= d_ie[i-1];
			d_en[i] <= d_en[i-1];
			d_busy[i] <= d_busy[i-1];
			d_rst[i] <= d_rst[i-1];
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	always_comb begin
		exp_pend = d_rst[1] ? '0 : (d_trig[1] & d_ie[1]);
		prev_pend = d_rst[2] ? '0 : (d_trig[2] & d_ie[2]);
		old_pend = d_rst[3] ? '0 : (d_trig[3] & d_ie[3]);
		exp_wake = |exp_pend;
		exp_ack = grant_of(prev_pend, d_en[1], d_busy[1], d_rst[1]);
		prev_ack = grant_of(old_pend, d_en[2], d_busy[2], d_rst[2]);
		exp_taken = !d_rst[1] && (|prev_ack);
		if (d_rst[1]) begin
			exp_vector = '0;
		end else begin
			exp_vector = {d_busy[1] & d_en[1], (|prev_ack) & d_en[1], one_hot_index(prev_ack)};
		end
		exp_rdata = (rd && addr == irq_pkg::IE_ADDR) ? m_ie : '0;
	end

	a_ie_hit: assert property (@(posedge clk) chk_on |-> (ie_hit == (addr == irq_pkg::IE_ADDR)))
	else begin
		$display("FAILED at %0t: ie_hit %b for addr %h", $time, $sampled(ie_hit),
			$sampled(addr));
		err_count = err_count + 1;
	end

	a_rdata: assert property (@(posedge clk) chk_on |-> (rdata == exp_rdata))
	else begin
		$display("FAILED at %0t: rdata %h, expected %h", $time, $sampled(rdata),
			$sampled(exp_rdata));
		err_count = err_count + 1;
	end

	a_wake: assert property (@(posedge clk) chk_on |-> (wake == exp_wake))
	else begin
		$display("FAILED at %0t: wake %b, expected %b", $time, $sampled(wake),
			$sampled(exp_wake));
		err_count = err_count + 1;
	end

	a_ack: assert property (@(posedge clk) chk_on |-> (ack == exp_ack))
	else begin
		$display("FAILED at %0t: ack %b, expected %b", $time, $sampled(ack),
			$sampled(exp_ack));
		err_count = err_count + 1;
	end

	// Masked-off sources must never be acknowledged
	a_ack_masked: assert property (@(posedge clk) chk_on |-> ((ack & ~d_ie[2]) == '0))
	else begin
		$display("FAILED at %0t: ack %b outside IE %b", $time, $sampled(ack),
			$sampled(d_ie[2]));
		err_count = err_count + 1;
	end

	a_vector: assert property (@(posedge clk) chk_on |-> (vector == exp_vector))
	else begin
		$display("FAILED at %0t: vector %b, expected %b", $time, $sampled(vector),
			$sampled(exp_vector));
		err_count = err_count + 1;
	end

	a_taken: assert property (@(posedge clk) chk_on |-> (taken == exp_taken))
	else begin
		$display("FAILED at %0t: taken %b, expected %b", $time, $sampled(taken),
			$sampled(exp_taken));
		err_count = err_count + 1;
	end

	a_reset_clear: assert property (@(posedge clk) (chk_on && d_rst[1]) |->
		(ack == '0 && vector == '0 && wake == 1'b0 && taken == 1'b0))
	else begin
		$display("FAILED at %0t: outputs not cleared after reset", $time);
		err_count = err_count + 1;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic bus_write(input logic [irq_pkg::ADDR_W-1:0] a,
		input logic [irq_pkg::DATA_W-1:0] d);
		@(posedge clk);
		addr <= a;
		wdata <= d;
		wr <= 1'b1;
		rd <= 1'b0;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	task automatic bus_read(input logic [irq_pkg::ADDR_W-1:0] a);
		@(posedge clk);
		addr <= a;
		rd <= 1'b1;
		@(posedge clk);
		rd <= 1'b0;
	endtask

	task automatic apply_request(input logic [irq_pkg::NUM_IRQ-1:0] t, input logic en,
		input logic busy);
		@(posedge clk);
		trig <= t;
		dispatch_en <= en;
		seq_busy <= busy;
	endtask

	task automatic pulse_reset(input int n);
		@(posedge clk);
		soft_reset <= 1'b1;
		repeat (n) @(posedge clk);
		soft_reset <= 1'b0;
	endtask

	task automatic run_random(input int cycles);
		int r;
		int s;
		for (int n = 0; n < cycles; n++) begin
			@(posedge clk);
			r = $random(seed);
			s = $random(seed);
			trig <= r[7:0];
			dispatch_en <= (r[10:8] != 3'd0);	// Mostly open
			seq_busy <= (r[13:11] == 3'd0);
			wr <= (r[16:14] == 3'd0);
			rd <= r[17];
			addr <= r[18] ? irq_pkg::IE_ADDR : {8'hFF, s[7:0]};
			wdata <= s[15:8];
		end
	endtask

	task automatic end_run();
		$display("Summary: %0d errors, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	initial begin : watchdog
		wait (cycle_count >= CYCLE_LIMIT);
		@(negedge clk);
		timeout_count = timeout_count + 1;
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		end_run();
	end

	initial begin : stimulus
		// IE write attempt and all requests held during power-on reset
		addr = irq_pkg::IE_ADDR;
		wdata = 8'hFF;
		wr = 1'b1;
		rd = 1'b1;
		trig = 8'hFF;
		dispatch_en = 1'b1;
		seq_busy = 1'b0;
		soft_reset = 1'b0;
		wait_cycles(3);
		wr <= 1'b0;
		rd <= 1'b0;
		while (por_reset) begin
			@(posedge clk);
		end

		// IE access
		bus_read(irq_pkg::IE_ADDR);
		bus_write(irq_pkg::IE_ADDR, 8'h5A);
		bus_read(irq_pkg::IE_ADDR);
		bus_write(16'hFFFE, 8'hFF);		// Neighbour of IE
		bus_write(16'h7FFF, 8'h00);
		bus_read(irq_pkg::IE_ADDR);
		bus_read(16'hFF0F);

		// Masking and wake with IE = 0x5A
		apply_request(8'hA5, 1'b1, 1'b0);
		wait_cycles(3);
		apply_request(8'hFF, 1'b1, 1'b0);
		wait_cycles(3);
		apply_request(8'h40, 1'b1, 1'b0);
		wait_cycles(3);

		// Priority, one new pattern every cycle
		bus_write(irq_pkg::IE_ADDR, 8'hFF);
		for (int i = 0; i < irq_pkg::NUM_IRQ; i++) begin
			apply_request(8'hFF << i, 1'b1, 1'b0);
		end
		apply_request(8'h81, 1'b1, 1'b0);
		apply_request(8'h90, 1'b1, 1'b0);
		apply_request(8'h00, 1'b1, 1'b0);
		wait_cycles(3);

		// Gating by seq_busy and dispatch_en
		apply_request(8'h10, 1'b1, 1'b1);
		wait_cycles(3);
		apply_request(8'h0C, 1'b0, 1'b0);
		wait_cycles(3);
		apply_request(8'h0C, 1'b0, 1'b1);
		wait_cycles(3);
		apply_request(8'h08, 1'b1, 1'b0);
		apply_request(8'h08, 1'b0, 1'b0);	// Dispatch drops under a live ack
		apply_request(8'h08, 1'b1, 1'b1);
		wait_cycles(3);

		// Reset with everything enabled and requested
		bus_write(irq_pkg::IE_ADDR, 8'hFF);
		apply_request(8'hFF, 1'b1, 1'b0);
		wait_cycles(3);
		pulse_reset(3);
		bus_read(irq_pkg::IE_ADDR);
		wait_cycles(3);

		run_random(RANDOM_CYCLES);
		apply_request(8'h00, 1'b1, 1'b0);
		wr <= 1'b0;
		rd <= 1'b0;
		wait_cycles(4);
		@(negedge clk);
		end_run();
	end

endmodule

//--- project.f
rtl/irq_pkg.sv
rtl/irq_enable_reg.sv
rtl/irq_request_stage.sv
rtl/irq_priority_stage.sv
rtl/irq_vector_stage.sv
rtl/irq_top.sv
test/tb_clock_gen.sv
test/tb_irq.sv

//--- Makefile
# Verilator flow for the interrupt controller
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= tb_irq
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Verification passed
VFLAGS ?= --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
